// ==== logic/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// the word size is also the address width, and addresses count words.
`define WORD_SIZE   16

// an address splits into tag, index and word offset from the top down.
`define TAG_SIZE    11
`define INDEX_SIZE  3

`define LINE_NUMBER 8
`define LINE_SIZE   4

// busy cycles a memory port shows before it completes a line transfer.
`define MEM_LATENCY 3

`endif

// ==== logic/cache_state_pkg.sv ====
package cache_state_pkg;

    // the instruction cache only ever refills, it has nothing to write back.
    typedef enum logic [1:0] {
        IC_IDLE,
        IC_REFILL,
        IC_RESPOND
    } icache_state_e;

    // a dirty victim goes out in DC_WRITEBACK before DC_REFILL brings in the new line.
    typedef enum logic [1:0] {
        DC_IDLE,
        DC_WRITEBACK,
        DC_REFILL,
        DC_RESPOND
    } dcache_state_e;

endpackage

// ==== logic/cache_subsystem.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_subsystem (
    input  logic                  Clk,
    input  logic                  i_arst_n,
    input  logic                  i_fetch,
    input  logic [`WORD_SIZE-1:0] i_fetch_addr,
    output logic                  o_fetch_done,
    output logic [`WORD_SIZE-1:0] o_fetch_data,
    output logic                  o_fetch_hit,
    input  logic                  i_load,
    input  logic                  i_store,
    input  logic [`WORD_SIZE-1:0] i_data_addr,
    input  logic [`WORD_SIZE-1:0] i_store_data,
    output logic                  o_data_done,
    output logic [`WORD_SIZE-1:0] o_load_data,
    output logic                  o_data_hit
);
    import mem_op_pkg::*;

    // the memory covers every line a word address can reach.
    localparam int LINE_ADDR_W = `TAG_SIZE + `INDEX_SIZE;
    localparam int LINE_BITS   = `LINE_SIZE * `WORD_SIZE;

    logic                   ic_mem_read;
    logic [LINE_ADDR_W-1:0] ic_line_addr;
    logic                   ic_mem_busy;
    logic [LINE_BITS-1:0]   ic_mem_line;

    mem_op_e                dc_mem_op;
    logic [LINE_ADDR_W-1:0] dc_line_addr;
    logic [LINE_BITS-1:0]   dc_wline;
    logic                   dc_mem_busy;
    logic [LINE_BITS-1:0]   dc_mem_line;

    icache icache_inst (
        .Clk             (Clk),
        .i_arst_n        (i_arst_n),
        .i_fetch         (i_fetch),
        .i_fetch_addr    (i_fetch_addr),
        .i_mem_busy      (ic_mem_busy),
        .i_mem_line      (ic_mem_line),
        .o_fetch_done    (o_fetch_done),
        .o_fetch_data    (o_fetch_data),
        .o_fetch_hit     (o_fetch_hit),
        .o_mem_read      (ic_mem_read),
        .o_mem_line_addr (ic_line_addr)
    );

    dcache dcache_inst (
        .Clk             (Clk),
        .i_arst_n        (i_arst_n),
        .i_load          (i_load),
        .i_store         (i_store),
        .i_data_addr     (i_data_addr),
        .i_store_data    (i_store_data),
        .i_mem_busy      (dc_mem_busy),
        .i_mem_line      (dc_mem_line),
        .o_data_done     (o_data_done),
        .o_load_data     (o_load_data),
        .o_data_hit      (o_data_hit),
        .o_mem_op        (dc_mem_op),
        .o_mem_line_addr (dc_line_addr),
        .o_mem_wline     (dc_wline)
    );

    line_memory #(
        .LINE_ADDR_BITS (LINE_ADDR_W)
    ) line_memory_inst (
        .Clk            (Clk),
        .i_arst_n       (i_arst_n),
        .i_p1_read      (ic_mem_read),
        .i_p1_line_addr (ic_line_addr),
        .i_p2_op        (dc_mem_op),
        .i_p2_line_addr (dc_line_addr),
        .i_p2_wline     (dc_wline),
        .o_p1_busy      (ic_mem_busy),
        .o_p1_line      (ic_mem_line),
        .o_p2_busy      (dc_mem_busy),
        .o_p2_line      (dc_mem_line)
    );

endmodule

// ==== logic/dcache.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module dcache (
    input  logic                             Clk,
    input  logic                             i_arst_n,
    input  logic                             i_load,
    input  logic                             i_store,
    input  logic [`WORD_SIZE-1:0]            i_data_addr,
    input  logic [`WORD_SIZE-1:0]            i_store_data,
    input  logic                             i_mem_busy,
    input  logic [`LINE_SIZE*`WORD_SIZE-1:0] i_mem_line,
    output logic                             o_data_done,
    output logic [`WORD_SIZE-1:0]            o_load_data,
    output logic                             o_data_hit,
    output mem_op_pkg::mem_op_e              o_mem_op,
    output logic [`TAG_SIZE+`INDEX_SIZE-1:0] o_mem_line_addr,
    output logic [`LINE_SIZE*`WORD_SIZE-1:0] o_mem_wline
);
    import cache_state_pkg::*;
    import mem_op_pkg::*;

    localparam int OFFSET_BITS = $clog2(`LINE_SIZE);
    localparam int LINE_BITS   = `LINE_SIZE * `WORD_SIZE;

    logic [`TAG_SIZE-1:0]    tag_arr  [`LINE_NUMBER];
    logic [LINE_BITS-1:0]    data_arr [`LINE_NUMBER];
    logic [`LINE_NUMBER-1:0] valid;
    logic [`LINE_NUMBER-1:0] dirty;

    dcache_state_e           state;
    logic [`TAG_SIZE-1:0]    req_tag;
    logic [`INDEX_SIZE-1:0]  req_index;
    logic [OFFSET_BITS-1:0]  req_offset;
    logic                    lookup_hit;
    logic                    accept;
    logic                    fill_done;

    assign req_tag    = i_data_addr[`WORD_SIZE-1 -: `TAG_SIZE];
    assign req_index  = i_data_addr[OFFSET_BITS +: `INDEX_SIZE];
    assign req_offset = i_data_addr[OFFSET_BITS-1:0];

    assign lookup_hit = valid[req_index] && (tag_arr[req_index] == req_tag);
    assign accept     = (i_load || i_store) && !o_data_done;
    assign fill_done  = (state == DC_REFILL) && !i_mem_busy;

    always_comb begin
        case (state)
            DC_WRITEBACK: o_mem_op = MEM_WRITE_LINE;
            DC_REFILL:    o_mem_op = MEM_READ_LINE;
            default:      o_mem_op = MEM_IDLE;
        endcase
    end

    // the victim goes back under the tag it was stored with, not the requested one.
    assign o_mem_line_addr = (state == DC_WRITEBACK) ? {tag_arr[req_index], req_index}
                                                     : {req_tag, req_index};
    assign o_mem_wline     = data_arr[req_index];

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state       <= DC_IDLE;
            valid       <= '0;
            dirty       <= '0;
            o_data_done <= 1'b0;
        end else begin
            o_data_done <= 1'b0;
            case (state)
                DC_IDLE: begin
                    if (accept) begin
                        if (lookup_hit) begin
                            state <= DC_RESPOND;
                        end else if (valid[req_index] && dirty[req_index]) begin
                            state <= DC_WRITEBACK;
                        end else begin
                            state <= DC_REFILL;
                        end
                    end
                end
                DC_WRITEBACK: begin
                    if (!i_mem_busy) begin
                        dirty[req_index] <= 1'b0;
                        state            <= DC_REFILL;
                    end
                end
                DC_REFILL: begin
                    if (!i_mem_busy) begin
                        valid[req_index] <= 1'b1;
                        dirty[req_index] <= 1'b0;
                        state            <= DC_RESPOND;
                    end
                end
                DC_RESPOND: begin
                    if (i_store) begin
                        dirty[req_index] <= 1'b1;
                    end
                    o_data_done <= 1'b1;
                    state       <= DC_IDLE;
                end
                default: state <= DC_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if ((state == DC_IDLE) && accept) begin
            o_data_hit <= lookup_hit;
        end
        if (fill_done) begin
            tag_arr[req_index]  <= req_tag;
            data_arr[req_index] <= i_mem_line;
        end
        // stores only ever touch a line that is present, after a hit or a refill.
        if (state == DC_RESPOND) begin
            if (i_store) begin
                data_arr[req_index][req_offset*`WORD_SIZE +: `WORD_SIZE] <= i_store_data;
            end else begin
                o_load_data <= data_arr[req_index][req_offset*`WORD_SIZE +: `WORD_SIZE];
            end
        end
    end

endmodule

// ==== logic/icache.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module icache (
    input  logic                             Clk,
    input  logic                             i_arst_n,
    input  logic                             i_fetch,
    input  logic [`WORD_SIZE-1:0]            i_fetch_addr,
    input  logic                             i_mem_busy,
    input  logic [`LINE_SIZE*`WORD_SIZE-1:0] i_mem_line,
    output logic                             o_fetch_done,
    output logic [`WORD_SIZE-1:0]            o_fetch_data,
    output logic                             o_fetch_hit,
    output logic                             o_mem_read,
    output logic [`TAG_SIZE+`INDEX_SIZE-1:0] o_mem_line_addr
);
    import cache_state_pkg::*;

    localparam int OFFSET_BITS = $clog2(`LINE_SIZE);
    localparam int LINE_BITS   = `LINE_SIZE * `WORD_SIZE;

    logic [`TAG_SIZE-1:0]    tag_arr  [`LINE_NUMBER];
    logic [LINE_BITS-1:0]    data_arr [`LINE_NUMBER];
    logic [`LINE_NUMBER-1:0] valid;

    icache_state_e           state;
    logic [`TAG_SIZE-1:0]    req_tag;
    logic [`INDEX_SIZE-1:0]  req_index;
    logic [OFFSET_BITS-1:0]  req_offset;
    logic                    lookup_hit;
    logic                    accept;
    logic                    fill_done;

    // the CPU holds the address until done, so it is used directly in every state.
    assign req_tag    = i_fetch_addr[`WORD_SIZE-1 -: `TAG_SIZE];
    assign req_index  = i_fetch_addr[OFFSET_BITS +: `INDEX_SIZE];
    assign req_offset = i_fetch_addr[OFFSET_BITS-1:0];

    assign lookup_hit = valid[req_index] && (tag_arr[req_index] == req_tag);

    // a request still high in the done cycle belongs to the access just finished.
    assign accept    = i_fetch && !o_fetch_done;
    assign fill_done = (state == IC_REFILL) && !i_mem_busy;

    assign o_mem_read      = (state == IC_REFILL);
    assign o_mem_line_addr = {req_tag, req_index};

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state        <= IC_IDLE;
            valid        <= '0;
            o_fetch_done <= 1'b0;
        end else begin
            o_fetch_done <= 1'b0;
            case (state)
                IC_IDLE: begin
                    if (accept) begin
                        state <= lookup_hit ? IC_RESPOND : IC_REFILL;
                    end
                end
                IC_REFILL: begin
                    if (!i_mem_busy) begin
                        valid[req_index] <= 1'b1;
                        state            <= IC_RESPOND;
                    end
                end
                IC_RESPOND: begin
                    o_fetch_done <= 1'b1;
                    state        <= IC_IDLE;
                end
                default: state <= IC_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if ((state == IC_IDLE) && accept) begin
            o_fetch_hit <= lookup_hit;
        end
        if (fill_done) begin
            tag_arr[req_index]  <= req_tag;
            data_arr[req_index] <= i_mem_line;
        end
        // after a refill the word comes from the line installed on the previous edge.
        if (state == IC_RESPOND) begin
            o_fetch_data <= data_arr[req_index][req_offset*`WORD_SIZE +: `WORD_SIZE];
        end
    end

endmodule

// ==== logic/line_memory.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module line_memory #(
    parameter int LINE_ADDR_BITS = 8
) (
    input  logic                             Clk,
    input  logic                             i_arst_n,
    input  logic                             i_p1_read,
    input  logic [LINE_ADDR_BITS-1:0]        i_p1_line_addr,
    input  mem_op_pkg::mem_op_e              i_p2_op,
    input  logic [LINE_ADDR_BITS-1:0]        i_p2_line_addr,
    input  logic [`LINE_SIZE*`WORD_SIZE-1:0] i_p2_wline,
    output logic                             o_p1_busy,
    output logic [`LINE_SIZE*`WORD_SIZE-1:0] o_p1_line,
    output logic                             o_p2_busy,
    output logic [`LINE_SIZE*`WORD_SIZE-1:0] o_p2_line
);
    import mem_op_pkg::*;

    localparam int DEPTH     = 1 << LINE_ADDR_BITS;
    localparam int LINE_BITS = `LINE_SIZE * `WORD_SIZE;
    localparam int CNT_BITS  = $clog2(`MEM_LATENCY + 1);
    localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(`MEM_LATENCY);

    logic [LINE_BITS-1:0] mem [DEPTH];
    logic [CNT_BITS-1:0]  p1_cnt;
    logic [CNT_BITS-1:0]  p2_cnt;
    logic                 p2_req;
    logic                 p2_write_done;

    // the count runs while a request is held and restarts once it completes.
    function automatic logic [CNT_BITS-1:0] next_count(input logic req,
                                                       input logic [CNT_BITS-1:0] cnt);
        if (!req || (cnt == LAST)) begin
            return '0;
        end
        return cnt + 1'b1;
    endfunction

    assign p2_req        = (i_p2_op != MEM_IDLE);
    assign p2_write_done = (i_p2_op == MEM_WRITE_LINE) && (p2_cnt == LAST);

    // busy is up from the first cycle of a request, so a stale low is never seen.
    assign o_p1_busy = i_p1_read && (p1_cnt != LAST);
    assign o_p2_busy = p2_req && (p2_cnt != LAST);

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            p1_cnt <= '0;
            p2_cnt <= '0;
        end else begin
            p1_cnt <= next_count(i_p1_read, p1_cnt);
            p2_cnt <= next_count(p2_req, p2_cnt);
        end
    end

    // writes land on the completing edge, so a port 1 read finishing then gets the old line.
    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (p2_write_done) begin
            mem[i_p2_line_addr] <= i_p2_wline;
        end
    end

    // the read lines are sampled on the edge that opens the single low-busy cycle.
    always_ff @(posedge Clk) begin
        if (i_p1_read && (p1_cnt == LAST - 1'b1)) begin
            o_p1_line <= mem[i_p1_line_addr];
        end
        if ((i_p2_op == MEM_READ_LINE) && (p2_cnt == LAST - 1'b1)) begin
            o_p2_line <= mem[i_p2_line_addr];
        end
    end

endmodule

// ==== logic/mem_op_pkg.sv ====
package mem_op_pkg;

    // opcode held on the data port of the line memory for the whole transfer.
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_READ_LINE,
        MEM_WRITE_LINE
    } mem_op_e;

endpackage

// ==== src.f ====
+incdir+logic
logic/cache_state_pkg.sv
logic/mem_op_pkg.sv
logic/icache.sv
logic/dcache.sv
logic/line_memory.sv
logic/cache_subsystem.sv
tb/tb_clock_gen.sv
tb/cache_props.sv
tb/cache_tb.sv

// ==== tb/cache_props.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_props (
    input logic                             Clk,
    input logic                             i_arst_n,
    input logic                             i_idle,
    input logic [`INDEX_SIZE-1:0]           i_index,
    input logic [`LINE_SIZE*`WORD_SIZE-1:0] i_line,
    input logic                             i_done,
    input logic                             i_mem_busy,
    input mem_op_pkg::mem_op_e              i_mem_op,
    input logic [`TAG_SIZE+`INDEX_SIZE-1:0] i_mem_line_addr
);

    // the arrays change only through a refill or a store, never from idle.
    no_write_in_idle: assert property (@(posedge Clk) disable iff (!i_arst_n)
        ($stable(i_index) && !$stable(i_line)) |-> !$past(i_idle))
        else $error("cache array written while the controller is idle");

    op_stable_while_busy: assert property (@(posedge Clk) disable iff (!i_arst_n)
        i_mem_busy |=> ($stable(i_mem_op) && $stable(i_mem_line_addr)))
        else $error("memory request changed while the memory was busy");

    done_single_pulse: assert property (@(posedge Clk) disable iff (!i_arst_n)
        i_done |=> !i_done)
        else $error("done stayed high for more than one cycle");

endmodule

bind icache cache_props icache_props_inst (
    .Clk             (Clk),
    .i_arst_n        (i_arst_n),
    .i_idle          (state == cache_state_pkg::IC_IDLE),
    .i_index         (req_index),
    .i_line          (data_arr[req_index]),
    .i_done          (o_fetch_done),
    .i_mem_busy      (i_mem_busy),
    .i_mem_op        (o_mem_read ? mem_op_pkg::MEM_READ_LINE : mem_op_pkg::MEM_IDLE),
    .i_mem_line_addr (o_mem_line_addr)
);

bind dcache cache_props dcache_props_inst (
    .Clk             (Clk),
    .i_arst_n        (i_arst_n),
    .i_idle          (state == cache_state_pkg::DC_IDLE),
    .i_index         (req_index),
    .i_line          (data_arr[req_index]),
    .i_done          (o_data_done),
    .i_mem_busy      (i_mem_busy),
    .i_mem_op        (o_mem_op),
    .i_mem_line_addr (o_mem_line_addr)
);

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb;

    localparam int          MAX_RECORDS  = 64;
    localparam int          RAW_WORDS    = 5 * MAX_RECORDS;
    localparam int          RESET_CYCLES = 10;
    localparam int          HIT_CYCLES   = 2;
    localparam int          MISS_BUDGET  = 2 + 2 * (`MEM_LATENCY + 1);
    localparam int          ACCESS_LIMIT = MISS_BUDGET + 4;
    localparam logic [31:0] SEED         = 32'ha598_0f00;

    typedef enum logic [3:0] {
        OP_IDLE       = 4'h0,
        OP_FETCH      = 4'h1,
        OP_LOAD       = 4'h2,
        OP_STORE      = 4'h3,
        OP_PAIR_FETCH = 4'h4,
        OP_PAIR_LOAD  = 4'h5,
        OP_END        = 4'hf
    } access_op_e;

    typedef struct packed {
        access_op_e            op;
        logic [`WORD_SIZE-1:0] addr;
        logic [`WORD_SIZE-1:0] wdata;
        logic [`WORD_SIZE-1:0] rdata;
        logic                  hit;
    } access_rec_t;

    logic                  Clk;
    logic                  arst_n;
    logic                  fetch;
    logic [`WORD_SIZE-1:0] fetch_addr;
    logic                  fetch_done;
    logic [`WORD_SIZE-1:0] fetch_data;
    logic                  fetch_hit;
    logic                  load;
    logic                  store;
    logic [`WORD_SIZE-1:0] data_addr;
    logic [`WORD_SIZE-1:0] store_data;
    logic                  data_done;
    logic [`WORD_SIZE-1:0] load_data;
    logic                  data_hit;

    logic [`WORD_SIZE-1:0] raw [RAW_WORDS];
    access_rec_t           recs [MAX_RECORDS];
    int                    rec_count = 0;

    tb_clock_gen #(
        .HALF_PERIOD_NS (5),
        .RESET_CYCLES   (RESET_CYCLES)
    ) clock_gen_inst (
        .o_clk    (Clk),
        .o_arst_n (arst_n)
    );

    cache_subsystem cache_subsystem_inst (
        .Clk          (Clk),
        .i_arst_n     (arst_n),
        .i_fetch      (fetch),
        .i_fetch_addr (fetch_addr),
        .o_fetch_done (fetch_done),
        .o_fetch_data (fetch_data),
        .o_fetch_hit  (fetch_hit),
        .i_load       (load),
        .i_store      (store),
        .i_data_addr  (data_addr),
        .i_store_data (store_data),
        .o_data_done  (data_done),
        .o_load_data  (load_data),
        .o_data_hit   (data_hit)
    );

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_data(input string name, input logic [`WORD_SIZE-1:0] got,
                              input logic [`WORD_SIZE-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_now($sformatf("mismatch %s: got 0x%0h cycles, expected 0x%0h", name, got, exp));
        end
    endtask

    // five words per record; a missing end marker still stops at the 16'hffff fill.
    task automatic load_records();
        int n;
        for (int i = 0; i < RAW_WORDS; i++) begin
            raw[i] = 16'hffff;
        end
        $readmemh("tb/cache_testdata.txt", raw);
        n = 0;
        while ((n < MAX_RECORDS) && (raw[5*n][3:0] != OP_END)) begin
            recs[n].op    = access_op_e'(raw[5*n][3:0]);
            recs[n].addr  = raw[5*n+1];
            recs[n].wdata = raw[5*n+2];
            recs[n].rdata = raw[5*n+3];
            recs[n].hit   = raw[5*n+4][0];
            n++;
        end
        if (n == 0) begin
            fail_now("no test records could be read from tb/cache_testdata.txt");
        end
        rec_count = n;
    endtask

    // outputs are sampled on the falling edge, half a cycle after they settle.
    task automatic wait_fetch_done(output int cycles);
        cycles = 0;
        do begin
            @(negedge Clk);
            cycles++;
            if (cycles > ACCESS_LIMIT) begin
                fail_now("the fetch never signalled done");
            end
        end while (fetch_done !== 1'b1);
    endtask

    task automatic wait_data_done(output int cycles);
        cycles = 0;
        do begin
            @(negedge Clk);
            cycles++;
            if (cycles > ACCESS_LIMIT) begin
                fail_now("the load or store never signalled done");
            end
        end while (data_done !== 1'b1);
    endtask

    task automatic run_fetch(input access_rec_t rec);
        int cycles;
        @(negedge Clk);
        fetch      = 1'b1;
        fetch_addr = rec.addr;
        wait_fetch_done(cycles);
        fetch = 1'b0;
        check_data("o_fetch_data", fetch_data, rec.rdata);
        check_hit("o_fetch_hit", fetch_hit, rec.hit);
        if (rec.hit) begin
            check_latency("fetch hit latency", cycles, HIT_CYCLES);
        end
    endtask

    task automatic run_data(input access_rec_t rec);
        int cycles;
        @(negedge Clk);
        load       = (rec.op == OP_LOAD);
        store      = (rec.op == OP_STORE);
        data_addr  = rec.addr;
        store_data = rec.wdata;
        wait_data_done(cycles);
        load  = 1'b0;
        store = 1'b0;
        if (rec.op == OP_LOAD) begin
            check_data("o_load_data", load_data, rec.rdata);
        end
        check_hit("o_data_hit", data_hit, rec.hit);
        if (rec.hit) begin
            check_latency("data hit latency", cycles, HIT_CYCLES);
        end
    endtask

    // both requests start on the same edge and run on separate memory ports.
    task automatic run_pair(input access_rec_t f_rec, input access_rec_t l_rec);
        int                    cycles;
        logic                  f_seen;
        logic                  l_seen;
        logic                  f_hit;
        logic                  l_hit;
        logic [`WORD_SIZE-1:0] f_word;
        logic [`WORD_SIZE-1:0] l_word;
        logic                  fetch_first;
        fetch_first = 1'($urandom % 2);
        @(negedge Clk);
        fetch      = 1'b1;
        fetch_addr = f_rec.addr;
        load       = 1'b1;
        data_addr  = l_rec.addr;
        cycles     = 0;
        f_seen     = 1'b0;
        l_seen     = 1'b0;
        while (!(f_seen && l_seen)) begin
            @(negedge Clk);
            cycles++;
            if (!f_seen && (fetch_done === 1'b1)) begin
                f_seen = 1'b1;
                fetch  = 1'b0;
                f_word = fetch_data;
                f_hit  = fetch_hit;
            end
            if (!l_seen && (data_done === 1'b1)) begin
                l_seen = 1'b1;
                load   = 1'b0;
                l_word = load_data;
                l_hit  = data_hit;
            end
            if (cycles > ACCESS_LIMIT) begin
                fail_now("the concurrent fetch and load did not both complete");
            end
        end
        if (fetch_first) begin
            check_data("o_fetch_data", f_word, f_rec.rdata);
            check_hit("o_fetch_hit", f_hit, f_rec.hit);
            check_data("o_load_data", l_word, l_rec.rdata);
            check_hit("o_data_hit", l_hit, l_rec.hit);
        end else begin
            check_data("o_load_data", l_word, l_rec.rdata);
            check_hit("o_data_hit", l_hit, l_rec.hit);
            check_data("o_fetch_data", f_word, f_rec.rdata);
            check_hit("o_fetch_hit", f_hit, f_rec.hit);
        end
    endtask

    initial begin
        int idx;
        fetch      = 1'b0;
        fetch_addr = '0;
        load       = 1'b0;
        store      = 1'b0;
        data_addr  = '0;
        store_data = '0;
        void'($urandom(SEED));
        load_records();
        wait (arst_n === 1'b1);
        idx = 0;
        while (idx < rec_count) begin
            case (recs[idx].op)
                OP_IDLE: repeat (recs[idx].wdata) @(negedge Clk);
                OP_FETCH: run_fetch(recs[idx]);
                OP_LOAD, OP_STORE: run_data(recs[idx]);
                OP_PAIR_FETCH: begin
                    if ((idx + 1 >= rec_count) || (recs[idx+1].op != OP_PAIR_LOAD)) begin
                        fail_now("a paired fetch record has no paired load after it");
                    end
                    run_pair(recs[idx], recs[idx+1]);
                    idx++;
                end
                default: fail_now("the test data holds an unknown opcode");
            endcase
            idx++;
        end
        @(negedge Clk);
        $display("Simulation finished: PASS");
        $finish;
    end

    // every record is allowed the cost of a dirty miss.
    initial begin
        int limit;
        wait (rec_count > 0);
        limit = rec_count * MISS_BUDGET + 100 + RESET_CYCLES;
        repeat (limit) @(posedge Clk);
        fail_now($sformatf("timeout: the run did not finish within %0d cycles", limit));
    end

endmodule

// ==== tb/cache_testdata.txt ====
// columns: opcode, word address, store data, expected read data, expected hit (all hex)
// opcode 0 idle for store-data cycles, 1 fetch, 2 load, 3 store, 4 and 5 paired fetch and load, f end
1 0040 0000 0000 0
1 0041 0000 0000 1
2 0100 0000 0000 0
2 0102 0000 0000 1
3 0104 beef 0000 0
2 0104 0000 beef 1
2 0105 0000 0000 1
2 0124 0000 0000 0
2 0104 0000 beef 0
3 0125 1234 0000 0
2 0104 0000 beef 0
2 0125 0000 1234 0
1 0104 0000 beef 0
3 0040 cafe 0000 0
2 0100 0000 0000 0
1 0040 0000 0000 1
1 0060 0000 0000 0
1 0040 0000 cafe 0
0 0000 0003 0000 0
4 0125 0000 1234 0
5 0040 0000 cafe 0
f 0000 0000 0000 0

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5,
    parameter int RESET_CYCLES   = 10
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

    // reset is released on a falling edge, well away from the sampling edge.
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule
